// ==== all.f ====
+incdir+bench
common/tetris_pkg.sv
hw/tracker/shape_decoder.sv
hw/tracker/tracker.sv
hw/line_clearer.sv
hw/game_ctrl.sv
hw/apb_regs.sv
hw/tetris_core.sv
bench/tb_tetris.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_tetris -o sim_tetris

# The testbench stops with a failing status on an error, the log decides
./obj_dir/sim_tetris > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int M_IDLE   = 0;
localparam int M_ACTIVE = 1;
localparam int M_OVER   = 3;

// Cell offsets per kind, orientation and cell
localparam int MODEL_DR [2][2][4] = '{'{'{0, 0, 1, 1}, '{0, 1, 1, 2}},
                                      '{'{0, 0, 1, 1}, '{0, 1, 1, 2}}};
localparam int MODEL_DC [2][2][4] = '{'{'{1, 2, 0, 1}, '{0, 0, 1, 1}},
                                      '{'{0, 1, 1, 2}, '{1, 0, 1, 0}}};

int m_frame [5][5];
int m_state;
int m_last_ok;
int m_lines;
int m_kind;
int m_orient;
int m_row;
int m_col;
int m_color;

function automatic void model_reset();
  foreach (m_frame[r, c]) m_frame[r][c] = 0;
  m_state   = M_IDLE;
  m_last_ok = 0;
  m_lines   = 0;
endfunction

// Bottom to top, a removed row makes the same index get tested again
function automatic void model_clear();
  int r;
  int removed;
  bit full;

  r       = 4;
  removed = 0;
  while (r >= 0) begin
    full = 1;
    for (int c = 0; c < 5; c++) if (m_frame[r][c] == 0) full = 0;
    if (full) begin
      for (int rr = r; rr > 0; rr--) begin
        for (int c = 0; c < 5; c++) m_frame[rr][c] = m_frame[rr-1][c];
      end
      for (int c = 0; c < 5; c++) m_frame[0][c] = 0;
      removed++;
    end else begin
      r--;
    end
  end
  m_lines = (m_lines + removed) % 16;
  m_state = M_IDLE;
endfunction

function automatic void model_apply(int op, int kind, int color);
  int  nr;
  int  nc;
  int  no;
  int  nk;
  int  ncol;
  int  cr [4];
  int  cc [4];
  bit  legal;
  bit  own;
  bit  spawn;

  spawn = (op == int'(OP_SPAWN));
  if (m_state == M_OVER || (m_state == M_IDLE && !spawn) || (m_state == M_ACTIVE && spawn)
      || (spawn && color == 0)) begin
    m_last_ok = 0;
    return;
  end
  nr = spawn ? 0 : m_row + (op == int'(OP_DOWN) ? 1 : 0);
  nc = spawn ? 1 : m_col + (op == int'(OP_RIGHT) ? 1 : 0) - (op == int'(OP_LEFT) ? 1 : 0);
  no = spawn ? 0 : ((op == int'(OP_ROR) || op == int'(OP_ROL)) ? 1 - m_orient : m_orient);
  nk = spawn ? kind : m_kind;
  ncol = spawn ? color : m_color;
  legal = 1;
  for (int i = 0; i < 4; i++) begin
    cr[i] = nr + MODEL_DR[nk][no][i];
    cc[i] = nc + MODEL_DC[nk][no][i];
    if (cr[i] < 0 || cr[i] > 4 || cc[i] < 0 || cc[i] > 4) begin
      legal = 0;
    end else if (m_frame[cr[i]][cc[i]] != 0) begin
      own = 0;
      for (int j = 0; j < 4; j++) begin
        if (!spawn && cr[i] == m_row + MODEL_DR[m_kind][m_orient][j]
            && cc[i] == m_col + MODEL_DC[m_kind][m_orient][j]) own = 1;
      end
      if (!own) legal = 0;
    end
  end
  m_last_ok = legal;
  if (!legal) begin
    if (spawn) m_state = M_OVER;
    else if (op == int'(OP_DOWN)) model_clear(); // Locked piece stays in the frame
    return;
  end
  if (!spawn) begin
    for (int j = 0; j < 4; j++) begin
      m_frame[m_row + MODEL_DR[m_kind][m_orient][j]][m_col + MODEL_DC[m_kind][m_orient][j]] = 0;
    end
  end
  for (int i = 0; i < 4; i++) m_frame[cr[i]][cc[i]] = ncol;
  m_row    = nr;
  m_col    = nc;
  m_orient = no;
  m_kind   = nk;
  m_color  = ncol;
  m_state  = M_ACTIVE;
endfunction

function automatic logic [31:0] model_row(int r);
  logic [31:0] d;

  d = '0;
  for (int c = 0; c < 5; c++) d = d | (32'(m_frame[r][c]) << (3 * c));
  return d;
endfunction

function automatic logic [31:0] model_status();
  return 32'((m_state == M_OVER ? 2 : 0) + m_last_ok * 4
             + (m_state == M_ACTIVE ? 8 : 0) + m_lines * 16);
endfunction

`endif

// ==== bench/tb_tetris.sv ====
`timescale 1ns/10ps

module tb_tetris;

  import tetris_pkg::*;

  localparam int CYCLE_LIMIT = 30000; // About 300 commands at 60 cycles plus margin

  logic     clk_i;
  logic     reset_i;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int       cycles;
  int       waits;
  event     check_req;
  event     check_done;

  `include "tb_model.svh"

  tetris_core UUT (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .apb_i  (apb_req),
    .apb_o  (apb_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  task automatic fail_stop(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int stalls);
    stalls = 0;
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      stalls++;
      @(negedge clk_i);
    end
    rdata = apb_rsp.prdata;
    @(posedge clk_i); // Completing edge
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output int stalls);
    logic [31:0] unused;

    apb_access(1'b1, addr, data, unused, stalls);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    int stalls;

    apb_access(1'b0, addr, '0, data, stalls);
  endtask

  task automatic wait_idle();
    logic [31:0] st;

    do apb_read(ADDR_STATUS, st); while (st[0]);
  endtask

  task automatic check_dut();
    -> check_req;
    @(check_done);
    @(posedge clk_i);
  endtask

  task automatic send_cmd(input int op, input int kind, input int color);
    apb_write(ADDR_CMD, 32'(op * 16 + kind * 8 + color), waits);
    model_apply(op, kind, color);
    wait_idle();
    check_dut();
  endtask

  task automatic apply_reset();
    reset_i <= 1'b1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    model_reset();
  endtask

  // Comparison of every readable register against the model
  initial begin : compare
    logic [31:0] got;
    logic [31:0] exp;

    forever begin
      @(check_req);
      apb_read(ADDR_STATUS, got);
      exp = model_status();
      assert (got === exp) else
        fail_stop($sformatf("FAILED t=%0t STATUS expected %h got %h", $time, exp, got));
      for (int r = 0; r < 5; r++) begin
        apb_read(ADDR_ROW0 + 8'(4 * r), got);
        exp = model_row(r);
        assert (got === exp) else
          fail_stop($sformatf("FAILED t=%0t ROW%0d expected %h got %h", $time, r, exp, got));
      end
      -> check_done;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] st;

    reset_i = 1'b1;
    apb_req = '0;
    cycles  = 0;
    void'($urandom(32'hc179_52dd));
    apply_reset();

    check_dut(); // Everything reads 0 after reset
    send_cmd(OP_RIGHT, 0, 0);

    for (int k = 0; k < 2; k++) begin
      apply_reset();
      send_cmd(OP_SPAWN, k, 0); // Colour 0 refused
      send_cmd(OP_SPAWN, k, 3 + k);
      repeat (4) send_cmd(OP_RIGHT, 0, 0);
      repeat (4) send_cmd(OP_LEFT, 0, 0);
      send_cmd(OP_ROR, 0, 0);
      repeat (3) send_cmd(OP_LEFT, 0, 0); // Blocked at the left wall
      send_cmd(OP_ROL, 0, 0);
      repeat (3) send_cmd(OP_DOWN, 0, 0);
      send_cmd(OP_ROL, 0, 0); // Upright from row 3 leaves the grid
      send_cmd(OP_ROR, 0, 0);
      send_cmd(OP_SPAWN, k, 5); // Spawn while active refused
      while (m_state == M_ACTIVE) send_cmd(OP_DOWN, 0, 0);
    end

    // Directed fill completes row 3
    apply_reset();
    send_cmd(OP_SPAWN, 0, 1);
    send_cmd(OP_LEFT, 0, 0);
    while (m_state == M_ACTIVE) send_cmd(OP_DOWN, 0, 0);
    send_cmd(OP_SPAWN, 1, 2);
    send_cmd(OP_RIGHT, 0, 0);
    while (m_state == M_ACTIVE) send_cmd(OP_DOWN, 0, 0);
    send_cmd(OP_SPAWN, 1, 6);
    send_cmd(OP_ROR, 0, 0);
    send_cmd(OP_LEFT, 0, 0);
    send_cmd(OP_DOWN, 0, 0);
    send_cmd(OP_ROR, 0, 0); // Blocked by a locked cell
    apb_write(ADDR_CMD, 32'(int'(OP_DOWN) * 16), waits); // Locks the piece
    model_apply(OP_DOWN, 0, 0);
    apb_read(ADDR_STATUS, st);
    assert (st[0] === 1'b1) else
      fail_stop($sformatf("FAILED t=%0t STATUS.busy expected 1 got %b", $time, st[0]));
    apb_write(ADDR_CMD, 32'(int'(OP_SPAWN) * 16 + 7), waits);
    assert (waits > 0) else fail_stop("A CMD write during the clear was not held back");
    model_apply(OP_SPAWN, 0, 7);
    assert (m_lines > 0) else fail_stop("The directed fill did not complete a row");
    wait_idle();
    check_dut();

    // Stack pieces until a spawn is blocked
    apply_reset();
    for (int n = 0; n < 12 && m_state != M_OVER; n++) begin
      send_cmd(OP_SPAWN, n % 2, 1 + n % 7);
      while (m_state == M_ACTIVE) send_cmd(OP_DOWN, 0, 0);
    end
    assert (m_state == M_OVER) else fail_stop("Stacked spawns never ended the game");
    send_cmd(OP_SPAWN, 0, 2);
    send_cmd(OP_DOWN, 0, 0);
    send_cmd(OP_LEFT, 0, 0);

    apply_reset();
    for (int n = 0; n < 250; n++) begin
      if (m_state == M_OVER) apply_reset();
      send_cmd($urandom_range(5, 0), $urandom_range(1, 0), $urandom_range(7, 1));
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== hw/tetris_core.sv ====
`timescale 1ns/10ps

module tetris_core (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  tetris_pkg::apb_req_t apb_i,
  output tetris_pkg::apb_rsp_t apb_o
);

  import tetris_pkg::*;

  logic    cmd_valid;
  cmd_t    cmd;
  logic    busy;      // High for the whole clear
  status_t status;
  frame_t  frame;

  //////////////////////////////////////////////////////////////////////
  // Host interface
  //////////////////////////////////////////////////////////////////////

  apb_regs u_apb_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .apb_i      (apb_i),
    .apb_o      (apb_o),
    .cmd_valid_o(cmd_valid),
    .cmd_o      (cmd),
    .busy_i     (busy),
    .status_i   (status),
    .frame_i    (frame)
  );

  //////////////////////////////////////////////////////////////////////
  // Playfield engine
  //////////////////////////////////////////////////////////////////////

  game_ctrl u_game_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_valid_i(cmd_valid),
    .cmd_i      (cmd),
    .busy_o     (busy),
    .status_o   (status),
    .frame_o    (frame)
  );

endmodule

// ==== hw/apb_regs.sv ====
`timescale 1ns/10ps

module apb_regs (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  tetris_pkg::apb_req_t apb_i,
  output tetris_pkg::apb_rsp_t apb_o,
  output logic                 cmd_valid_o,
  output tetris_pkg::cmd_t     cmd_o,
  input  logic                 busy_i,
  input  tetris_pkg::status_t  status_i,
  input  tetris_pkg::frame_t   frame_i
);

  import tetris_pkg::*;

  logic        access; // APB access phase
  logic        cmd_wr;
  logic        cmd_stall;
  logic [31:0] rdata;

  assign access    = apb_i.psel && apb_i.penable;
  assign cmd_wr    = access && apb_i.pwrite && (apb_i.paddr == ADDR_CMD);
  assign cmd_stall = cmd_wr && busy_i;

  //////////////////////////////////////////////////////////////////////
  // Command hand-off
  //////////////////////////////////////////////////////////////////////

  // Pulse lands on the edge that completes the write
  assign cmd_valid_o = cmd_wr && !busy_i;
  assign cmd_o       = cmd_t'(apb_i.pwdata[6:0]);

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  always_comb begin : read_mux
    rdata = '0;
    if (apb_i.paddr == ADDR_STATUS) begin
      rdata[7:0] = status_i;
    end
    for (int r = 0; r < GRID_ROWS; r++) begin
      if (apb_i.paddr == ADDR_ROW0 + 8'(4 * r)) begin
        rdata[GRID_COLS*COLOR_W-1:0] = frame_i[r]; // Column c at bits 3c+2:3c
      end
    end
  end

  assign apb_o.prdata = rdata;
  assign apb_o.pready = !cmd_stall; // Only a CMD write during a clear waits

  a_penable_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_i.penable |-> apb_i.psel);

  // A stalled write stays on the bus unchanged
  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_stall |=> access && apb_i.pwrite && $stable(apb_i.paddr)
                  && $stable(apb_i.pwdata));

endmodule

// ==== hw/game_ctrl.sv ====
`timescale 1ns/10ps

module game_ctrl (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                cmd_valid_i,
  input  tetris_pkg::cmd_t    cmd_i,
  output logic                busy_o,
  output tetris_pkg::status_t status_o,
  output tetris_pkg::frame_t  frame_o
);

  import tetris_pkg::*;

  game_state_t state_q;
  frame_t      frame_q;
  piece_t      piece_q;
  logic        last_ok_q;
  logic [3:0]  lines_q; // Wraps at 16

  frame_t     trk_frame;
  piece_t     trk_piece;
  logic       trk_ok;
  frame_t     clr_frame;
  logic [2:0] removed;
  logic       clear_start;
  logic       clear_done;
  logic       spawn_req;
  logic       move_req;
  logic       accept;

  tracker u_tracker (
    .frame_i(frame_q),
    .piece_i(piece_q),
    .op_i   (cmd_i.op),
    .kind_i (cmd_i.kind),
    .color_i(cmd_i.color),
    .frame_o(trk_frame),
    .piece_o(trk_piece),
    .ok_o   (trk_ok)
  );

  line_clearer u_line_clearer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (clear_start),
    .frame_i  (frame_q),   // Locked piece is already in the frame
    .done_o   (clear_done),
    .frame_o  (clr_frame),
    .removed_o(removed)
  );

  //////////////////////////////////////////////////////////////////////
  // Command qualification
  //////////////////////////////////////////////////////////////////////

  assign spawn_req = cmd_valid_i && (state_q == GS_IDLE) && (cmd_i.op == OP_SPAWN)
                     && (cmd_i.color != '0);
  assign move_req  = cmd_valid_i && (state_q == GS_ACTIVE) && (cmd_i.op != OP_SPAWN);
  assign accept    = (spawn_req || move_req) && trk_ok;

  // Blocked down move locks the piece
  assign clear_start = move_req && !trk_ok && (cmd_i.op == OP_DOWN);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= GS_IDLE;
      frame_q   <= '0;
      last_ok_q <= 1'b0;
      lines_q   <= '0;
    end else begin
      if (cmd_valid_i) last_ok_q <= accept;
      if (accept) frame_q <= trk_frame;
      case (state_q)
        GS_IDLE:   if (spawn_req) state_q <= trk_ok ? GS_ACTIVE : GS_OVER;
        GS_ACTIVE: if (clear_start) state_q <= GS_CLEAR;
        GS_CLEAR: begin
          if (clear_done) begin
            frame_q <= clr_frame;
            lines_q <= lines_q + 4'(removed);
            state_q <= GS_IDLE;
          end
        end
        default: state_q <= state_q; // Game over holds until reset
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) piece_q <= trk_piece;
  end

  assign busy_o                = (state_q == GS_CLEAR);
  assign status_o.busy         = busy_o;
  assign status_o.game_over    = (state_q == GS_OVER);
  assign status_o.last_ok      = last_ok_q;
  assign status_o.piece_active = (state_q == GS_ACTIVE);
  assign status_o.lines        = lines_q;
  assign frame_o               = frame_q;

  // Host side must hold commands back during a clear
  a_no_cmd_in_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == GS_CLEAR) |-> !cmd_valid_i);

  a_over_final: assert property (@(posedge clk_i) disable iff (reset_i)
    status_o.game_over |=> status_o.game_over && !status_o.piece_active);

endmodule

// ==== hw/line_clearer.sv ====
`timescale 1ns/10ps

module line_clearer (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  tetris_pkg::frame_t frame_i,
  output logic               done_o,
  output tetris_pkg::frame_t frame_o,
  output logic [2:0]         removed_o
);

  import tetris_pkg::*;

  logic       busy_q;
  logic [2:0] row_q;     // Row under test, walks upward
  logic [2:0] removed_q;
  frame_t     work_q;
  frame_t     shifted;
  logic       row_full;

  always_comb begin : full_test
    row_full = 1'b1;
    for (int c = 0; c < GRID_COLS; c++) begin
      if (work_q[row_q][c] == '0) row_full = 1'b0;
    end
  end

  // Drop everything above the tested row by one
  always_comb begin : shift
    shifted[0] = '0;
    for (int r = 1; r < GRID_ROWS; r++) begin
      shifted[r] = (3'(r) <= row_q) ? work_q[r-1] : work_q[r];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      row_q     <= '0;
      removed_q <= '0;
    end else if (start_i) begin
      busy_q    <= 1'b1;
      row_q     <= 3'(GRID_ROWS - 1); // Bottom row first
      removed_q <= '0;
    end else if (busy_q) begin
      if (row_full) begin
        removed_q <= removed_q + 3'd1; // Same row is tested again
      end else if (row_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        row_q <= row_q - 3'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      work_q <= frame_i;
    end else if (busy_q && row_full) begin
      work_q <= shifted;
    end
  end

  assign done_o    = busy_q && !row_full && (row_q == '0);
  assign frame_o   = work_q;
  assign removed_o = removed_q;

  a_no_restart: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> !busy_q);

endmodule

// ==== hw/tracker/tracker.sv ====
`timescale 1ns/10ps

module tracker (
  input  tetris_pkg::frame_t      frame_i,
  input  tetris_pkg::piece_t      piece_i,
  input  tetris_pkg::op_t         op_i,
  input  tetris_pkg::piece_kind_t kind_i,
  input  tetris_pkg::color_t      color_i,
  output tetris_pkg::frame_t      frame_o,
  output tetris_pkg::piece_t      piece_o,
  output logic                    ok_o
);

  import tetris_pkg::*;

  piece_t cand;        // Piece after the op
  cells_t old_cells;
  cells_t new_cells;
  logic   old_in_grid;
  logic   new_in_grid;
  logic   spawn;
  logic   known_op;

  assign spawn = (op_i == OP_SPAWN);

  always_comb begin : candidate
    cand     = piece_i;
    known_op = 1'b1;
    case (op_i)
      OP_RIGHT: cand.col = piece_i.col + 3'd1;
      OP_LEFT:  cand.col = piece_i.col - 3'd1;
      OP_DOWN:  cand.row = piece_i.row + 3'd1;
      OP_ROR, OP_ROL: cand.orient = ~piece_i.orient; // Both directions toggle
      OP_SPAWN: begin
        cand.kind   = kind_i;
        cand.orient = 1'b0;
        cand.row    = 3'(SPAWN_ROW);
        cand.col    = 3'(SPAWN_COL);
        cand.color  = color_i;
      end
      default: known_op = 1'b0; // Spare opcodes are refused
    endcase
  end

  shape_decoder u_old_shape (
    .piece_i  (piece_i),
    .cells_o  (old_cells),
    .in_grid_o(old_in_grid)
  );

  shape_decoder u_new_shape (
    .piece_i  (cand),
    .cells_o  (new_cells),
    .in_grid_o(new_in_grid)
  );

  //////////////////////////////////////////////////////////////////////
  // Legality against the frame
  //////////////////////////////////////////////////////////////////////

  always_comb begin : check
    logic own;
    logic hit;

    ok_o = known_op && new_in_grid && (spawn || old_in_grid);
    for (int i = 0; i < 4; i++) begin
      own = 1'b0;
      for (int j = 0; j < 4; j++) begin
        if (!spawn && new_cells[i] == old_cells[j]) own = 1'b1; // Own cell
      end
      hit = (frame_i[new_cells[i].row][new_cells[i].col] != '0);
      if (hit && !own) ok_o = 1'b0;
    end
  end

  always_comb begin : rewrite
    frame_o = frame_i;
    piece_o = piece_i;
    if (ok_o) begin
      if (!spawn) begin
        for (int i = 0; i < 4; i++) frame_o[old_cells[i].row][old_cells[i].col] = '0;
      end
      for (int i = 0; i < 4; i++) begin
        frame_o[new_cells[i].row][new_cells[i].col] = cand.color;
      end
      piece_o = cand;
    end
  end

endmodule

// ==== hw/tracker/shape_decoder.sv ====
`timescale 1ns/10ps

module shape_decoder (
  input  tetris_pkg::piece_t piece_i,
  output tetris_pkg::cells_t cells_o,
  output logic               in_grid_o
);

  import tetris_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Anchor plus table offset for each of the four cells
  //////////////////////////////////////////////////////////////////////

  always_comb begin : decode
    offset_t    off;
    logic [3:0] row_sum; // One spare bit to see the bottom edge
    logic [3:0] col_sum;

    in_grid_o = 1'b1;
    cells_o   = '0;

    for (int i = 0; i < 4; i++) begin
      off     = SHAPE_TABLE[piece_i.kind][piece_i.orient][i];
      row_sum = {1'b0, piece_i.row} + {2'b00, off.dr};
      col_sum = {1'b0, piece_i.col} + {2'b00, off.dc};

      cells_o[i].row = row_sum[2:0];
      cells_o[i].col = col_sum[2:0];

      // A left shift from column 0 wraps to 7 and fails here as well
      if (row_sum >= 4'(GRID_ROWS)) begin
        in_grid_o = 1'b0;
      end
      if (col_sum >= 4'(GRID_COLS)) begin
        in_grid_o = 1'b0;
      end
    end
  end

endmodule

// ==== common/tetris_pkg.sv ====
package tetris_pkg;

  //////////////////////////////////////////////////////////////////////
  // Grid geometry and register map
  //////////////////////////////////////////////////////////////////////

  localparam int GRID_ROWS = 5; // Row 0 is the top row
  localparam int GRID_COLS = 5;
  localparam int COLOR_W   = 3;
  localparam int SPAWN_ROW = 0; // Anchor of a fresh piece
  localparam int SPAWN_COL = 1;

  localparam logic [7:0] ADDR_CMD    = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;
  localparam logic [7:0] ADDR_ROW0   = 8'h10; // Next rows at 4 byte steps

  typedef logic [COLOR_W-1:0] color_t; // 0 marks an empty cell
  typedef color_t [GRID_ROWS-1:0][GRID_COLS-1:0] frame_t;

  typedef enum logic [2:0] {
    OP_RIGHT,
    OP_LEFT,
    OP_ROR,
    OP_ROL,
    OP_DOWN,
    OP_SPAWN
  } op_t;

  typedef enum logic {PIECE_S, PIECE_Z} piece_kind_t;

  typedef enum logic [1:0] {GS_IDLE, GS_ACTIVE, GS_CLEAR, GS_OVER} game_state_t;

  typedef struct packed {
    piece_kind_t kind;
    logic        orient;
    logic [2:0]  row;    // Anchor row
    logic [2:0]  col;    // Anchor column
    color_t      color;
  } piece_t;

  // Low 7 bits of a CMD write
  typedef struct packed {
    op_t         op;
    piece_kind_t kind;
    color_t      color;
  } cmd_t;

  // Declared MSB first so busy lands in bit 0
  typedef struct packed {
    logic [3:0] lines;
    logic       piece_active;
    logic       last_ok;
    logic       game_over;
    logic       busy;
  } status_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Shape offsets, indexed by kind, orientation and cell
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [2:0] row;
    logic [2:0] col;
  } cell_t;

  typedef cell_t [3:0] cells_t;

  typedef struct packed {
    logic [1:0] dr;
    logic [1:0] dc;
  } offset_t;

  localparam offset_t SHAPE_TABLE [2][2][4] = '{
    '{'{'{2'd0, 2'd1}, '{2'd0, 2'd2}, '{2'd1, 2'd0}, '{2'd1, 2'd1}},  // S flat
      '{'{2'd0, 2'd0}, '{2'd1, 2'd0}, '{2'd1, 2'd1}, '{2'd2, 2'd1}}}, // S upright
    '{'{'{2'd0, 2'd0}, '{2'd0, 2'd1}, '{2'd1, 2'd1}, '{2'd1, 2'd2}},  // Z flat
      '{'{2'd0, 2'd1}, '{2'd1, 2'd0}, '{2'd1, 2'd1}, '{2'd2, 2'd0}}}  // Z upright
  };

endpackage
